//--- all.f
hdl/procPkg.sv
hdl/pipeIf.sv
hdl/apbHost.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/result.sv
hdl/proc.sv
tb/clockGen.sv
tb/procTb.sv

//--- hdl/apbHost.sv
// APB host port
`timescale 1ns/1ps

module apbHost (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  procPkg::apbAddr_t    paddr,
   input  procPkg::word_t       pwdata,
   output logic                 pready,
   output procPkg::word_t       prdata,
   output logic                 pslverr,
   input  procPkg::runState_t   runState,
   input  logic                 halt,
   input  logic                 err,
   input  procPkg::word_t       retired,
   input  procPkg::word_t       dbgData,
   output logic                 imemWrEn,
   output procPkg::imemAddr_t   imemWrAddr,
   output procPkg::word_t       imemWrData,
   output logic                 start,
   output procPkg::regIdx_t     dbgIdx
);

   logic           setup;
   logic           wrAccess;
   logic           aligned;
   logic           isImem;
   logic           isCtrl;
   logic           isRetired;
   logic           isReg;
   logic           busy;
   logic           errNext;
   procPkg::word_t rdNext;

   assign setup    = psel & ~penable;
   assign wrAccess = psel & penable & pwrite;
   assign busy     = (runState == procPkg::Running) || (runState == procPkg::Draining);

   // Address decode
   assign aligned   = (paddr[1:0] == 2'b00);
   assign isImem    = aligned && (paddr <= procPkg::AddrImemLast);
   assign isCtrl    = (paddr == procPkg::AddrCtrl);
   assign isRetired = (paddr == procPkg::AddrRetired);
   assign isReg     = aligned && (paddr >= procPkg::AddrRegBase) &&
                      (int'(paddr) < int'(procPkg::AddrRegBase) + 4 * procPkg::NumRegs);

   assign errNext = ~(isImem | isCtrl | isRetired | isReg) ||
                    (pwrite && (isImem || isCtrl) && busy);

   always_comb begin
      rdNext = '0;
      if (isCtrl) begin
         rdNext = {13'd0, err, halt, busy};
      end else if (isRetired) begin
         rdNext = retired;
      end else if (isReg) begin
         rdNext = dbgData;
      end
   end

   // Response decided in setup and presented in access
   always_ff @(posedge clk) begin
      if (reset) begin
         pslverr <= 1'b0;
      end else if (setup) begin
         pslverr <= errNext;
      end else begin
         pslverr <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (setup) begin
         prdata <= rdNext;
      end
   end

   assign pready = 1'b1;

   // Accepted writes only
   assign imemWrEn   = wrAccess & isImem & ~pslverr;
   assign imemWrAddr = paddr[9:2];
   assign imemWrData = pwdata;
   assign start      = wrAccess & isCtrl & ~pslverr & pwdata[0];

   assign dbgIdx = paddr[4:2];

endmodule

//--- hdl/decode.sv
// Decode stage and register file
`timescale 1ns/1ps

module decode (
   input  logic               clk,
   input  logic               reset,
   input  procPkg::word_t     instr,
   input  logic               instrValid,
   input  logic               wrEn,
   input  procPkg::regIdx_t   wrIdx,
   input  procPkg::word_t     wrData,
   input  procPkg::regIdx_t   dbgIdx,
   output procPkg::word_t     dbgData,
   output logic               stopFetch,
   decodeIf.src               idOut
);

   procPkg::word_t   regs [procPkg::NumRegs];

   procPkg::opcode_t opcode;
   procPkg::regIdx_t rd;
   procPkg::regIdx_t rs;
   procPkg::regIdx_t rt;
   procPkg::word_t   immExt;
   procPkg::word_t   rdVal;
   procPkg::word_t   rsVal;
   procPkg::word_t   rtVal;
   procPkg::word_t   opA;
   logic             isHalt;
   logic             isIllegal;

   // Instruction fields
   assign opcode = instr[15:12];
   assign rd     = instr[11:9];
   assign rs     = instr[8:6];
   assign rt     = instr[5:3];
   assign immExt = {{8{instr[7]}}, instr[7:0]};

   // Register file
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Same-cycle write is visible to the reader
   assign rdVal = (wrEn && wrIdx == rd) ? wrData : regs[rd];
   assign rsVal = (wrEn && wrIdx == rs) ? wrData : regs[rs];
   assign rtVal = (wrEn && wrIdx == rt) ? wrData : regs[rt];

   // SLBI shifts the old rd
   assign opA = (opcode == procPkg::OpSlbi) ? rdVal : rsVal;

   assign dbgData = regs[dbgIdx];

   // Anything past HALT or a bad opcode is squashed in fetch
   assign isHalt    = (opcode == procPkg::OpHalt);
   assign isIllegal = (opcode > procPkg::OpSlbi) && !isHalt;
   assign stopFetch = instrValid && (isHalt || isIllegal);

   // ID/EX register
   always_ff @(posedge clk) begin
      if (reset) begin
         idOut.valid <= 1'b0;
      end else begin
         idOut.valid <= instrValid;
      end
   end

   always_ff @(posedge clk) begin
      idOut.opcode <= opcode;
      idOut.rd     <= rd;
      idOut.rs     <= rs;
      idOut.rt     <= rt;
      idOut.opA    <= opA;
      idOut.opB    <= rtVal;
      idOut.imm    <= immExt;
   end

endmodule

//--- hdl/execute.sv
// Execute stage
`timescale 1ns/1ps

module execute (
   input  logic               clk,
   input  logic               reset,
   input  logic               wrEn,
   input  procPkg::regIdx_t   wrIdx,
   input  procPkg::word_t     wrData,
   decodeIf.dst               idIn,
   retireIf.src               rtOut
);

   procPkg::regIdx_t idxA;
   procPkg::word_t   a;
   procPkg::word_t   b;
   procPkg::word_t   aluOut;
   logic [31:0]      rotWide;
   logic             writes;
   logic             isHalt;
   logic             isIllegal;

   // Forward the instruction retiring this cycle
   assign idxA = (idIn.opcode == procPkg::OpSlbi) ? idIn.rd : idIn.rs;
   assign a    = (wrEn && wrIdx == idxA) ? wrData : idIn.opA;
   assign b    = (wrEn && wrIdx == idIn.rt) ? wrData : idIn.opB;

   assign rotWide = {a, a} >> b[3:0];

   always_comb begin
      aluOut    = '0;
      writes    = 1'b1;
      isHalt    = 1'b0;
      isIllegal = 1'b0;
      case (idIn.opcode)
         procPkg::OpNop:  writes = 1'b0;
         procPkg::OpAdd:  aluOut = a + b;
         procPkg::OpSub:  aluOut = a - b;
         procPkg::OpAnd:  aluOut = a & b;
         procPkg::OpXor:  aluOut = a ^ b;
         procPkg::OpSll:  aluOut = a << b[3:0];
         procPkg::OpRor:  aluOut = rotWide[15:0];
         procPkg::OpSeq:  aluOut = procPkg::word_t'(a == b);
         procPkg::OpSlt:  aluOut = procPkg::word_t'($signed(a) < $signed(b));
         procPkg::OpLbi:  aluOut = idIn.imm;
         procPkg::OpSlbi: aluOut = {a[7:0], idIn.imm[7:0]};
         procPkg::OpHalt: begin
            writes = 1'b0;
            isHalt = 1'b1;
         end
         default: begin
            writes    = 1'b0;
            isIllegal = 1'b1;
         end
      endcase
   end

   // EX/RT register
   always_ff @(posedge clk) begin
      if (reset) begin
         rtOut.valid   <= 1'b0;
         rtOut.wrEn    <= 1'b0;
         rtOut.halt    <= 1'b0;
         rtOut.illegal <= 1'b0;
      end else begin
         rtOut.valid   <= idIn.valid;
         rtOut.wrEn    <= idIn.valid & writes;
         rtOut.halt    <= idIn.valid & isHalt;
         rtOut.illegal <= idIn.valid & isIllegal;
      end
   end

   always_ff @(posedge clk) begin
      rtOut.rd    <= idIn.rd;
      rtOut.value <= aluOut;
   end

endmodule

//--- hdl/fetch.sv
// Fetch stage
`timescale 1ns/1ps

module fetch (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 stopFetch,
   input  logic                 haltRetired,
   input  logic                 imemWrEn,
   input  procPkg::imemAddr_t   imemWrAddr,
   input  procPkg::word_t       imemWrData,
   output procPkg::runState_t   runState,
   output procPkg::word_t       instr,
   output logic                 instrValid
);

   procPkg::word_t     imem [procPkg::ImemWords];
   procPkg::imemAddr_t pc;

   // Host load port
   always_ff @(posedge clk) begin
      if (imemWrEn) begin
         imem[imemWrAddr] <= imemWrData;
      end
   end

   // Registered read
   always_ff @(posedge clk) begin
      instr <= imem[pc];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         runState   <= procPkg::Idle;
         pc         <= '0;
         instrValid <= 1'b0;
      end else begin
         instrValid <= 1'b0;
         case (runState)
            procPkg::Idle, procPkg::Stopped: begin
               if (start) begin
                  runState <= procPkg::Running;
                  pc       <= '0;
               end
            end
            procPkg::Running: begin
               // Word read this cycle is dropped
               if (stopFetch) begin
                  runState <= procPkg::Draining;
               end else begin
                  instrValid <= 1'b1;
                  pc         <= pc + 1'b1;
               end
            end
            procPkg::Draining: begin
               if (haltRetired) begin
                  runState <= procPkg::Stopped;
               end
            end
         endcase
      end
   end

endmodule

//--- hdl/pipeIf.sv
// Pipeline stage interfaces
`timescale 1ns/1ps

// ID/EX stage register contents
interface decodeIf;
   logic             valid;
   procPkg::opcode_t opcode;
   procPkg::regIdx_t rd;
   procPkg::regIdx_t rs;
   procPkg::regIdx_t rt;
   procPkg::word_t   opA;
   procPkg::word_t   opB;
   procPkg::word_t   imm;

   modport src (
      output valid, opcode, rd, rs, rt, opA, opB, imm
   );

   modport dst (
      input valid, opcode, rd, rs, rt, opA, opB, imm
   );
endinterface

// EX/RT stage register contents
interface retireIf;
   logic             valid;
   logic             wrEn;
   procPkg::regIdx_t rd;
   procPkg::word_t   value;
   logic             halt;
   logic             illegal;

   modport src (
      output valid, wrEn, rd, value, halt, illegal
   );

   modport dst (
      input valid, wrEn, rd, value, halt, illegal
   );
endinterface

//--- hdl/proc.sv
// Pipelined processor top
`timescale 1ns/1ps

module proc (
   input  logic                clk,
   input  logic                reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  procPkg::apbAddr_t   paddr,
   input  procPkg::word_t      pwdata,
   output logic                pready,
   output procPkg::word_t      prdata,
   output logic                pslverr,
   output logic                halt,
   output logic                err
);

   procPkg::runState_t runState;
   procPkg::imemAddr_t imemWrAddr;
   procPkg::word_t     imemWrData;
   procPkg::word_t     instr;
   procPkg::word_t     retired;
   procPkg::word_t     dbgData;
   procPkg::word_t     wrData;
   procPkg::regIdx_t   wrIdx;
   procPkg::regIdx_t   dbgIdx;
   logic               imemWrEn;
   logic               start;
   logic               instrValid;
   logic               stopFetch;
   logic               wrEn;
   logic               illegalSeen;

   decodeIf idIf ();
   retireIf rtIf ();

   apbHost host (
      .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .pready, .prdata, .pslverr, .runState, .halt, .err, .retired, .dbgData,
      .imemWrEn, .imemWrAddr, .imemWrData, .start, .dbgIdx
   );

   fetch fetchStage (
      .clk, .reset, .start, .stopFetch, .haltRetired(halt),
      .imemWrEn, .imemWrAddr, .imemWrData, .runState, .instr, .instrValid
   );

   decode decodeStage (
      .clk, .reset, .instr, .instrValid, .wrEn, .wrIdx, .wrData,
      .dbgIdx, .dbgData, .stopFetch, .idOut(idIf.src)
   );

   execute executeStage (
      .clk, .reset, .wrEn, .wrIdx, .wrData, .idIn(idIf.dst), .rtOut(rtIf.src)
   );

   result resultStage (
      .clk, .reset, .start, .rtIn(rtIf.dst), .wrEn, .wrIdx, .wrData,
      .halt, .err(illegalSeen), .retired
   );

   // Illegal opcode is the only error source
   assign err = illegalSeen;

endmodule

//--- hdl/procPkg.sv
// Processor shared definitions
package procPkg;

   // Data path types
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;
   typedef logic [3:0]  opcode_t;
   typedef logic [7:0]  imemAddr_t;
   typedef logic [11:0] apbAddr_t;

   // Fetch run state
   typedef enum logic [1:0] {
      Idle,
      Running,
      Draining,
      Stopped
   } runState_t;

   // Opcodes with 11 to 14 left illegal
   localparam opcode_t OpNop  = 4'd0;
   localparam opcode_t OpAdd  = 4'd1;
   localparam opcode_t OpSub  = 4'd2;
   localparam opcode_t OpAnd  = 4'd3;
   localparam opcode_t OpXor  = 4'd4;
   localparam opcode_t OpSll  = 4'd5;
   localparam opcode_t OpRor  = 4'd6;
   localparam opcode_t OpSeq  = 4'd7;
   localparam opcode_t OpSlt  = 4'd8;
   localparam opcode_t OpLbi  = 4'd9;
   localparam opcode_t OpSlbi = 4'd10;
   localparam opcode_t OpHalt = 4'd15;

   // Storage sizes
   localparam int ImemWords = 256;
   localparam int NumRegs   = 8;

   // APB address map
   localparam apbAddr_t AddrImemLast = 12'h3FC;
   localparam apbAddr_t AddrCtrl     = 12'h400;
   localparam apbAddr_t AddrRetired  = 12'h404;
   // r0 to r7 on consecutive words
   localparam apbAddr_t AddrRegBase  = 12'h440;

endpackage

//--- hdl/result.sv
// Result stage
`timescale 1ns/1ps

module result (
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   retireIf.dst               rtIn,
   output logic               wrEn,
   output procPkg::regIdx_t   wrIdx,
   output procPkg::word_t     wrData,
   output logic               halt,
   output logic               err,
   output procPkg::word_t     retired
);

   // Register write port
   assign wrEn   = rtIn.valid & rtIn.wrEn;
   assign wrIdx  = rtIn.rd;
   assign wrData = rtIn.value;

   // Status held until the next run
   always_ff @(posedge clk) begin
      if (reset || start) begin
         halt    <= 1'b0;
         err     <= 1'b0;
         retired <= '0;
      end else if (rtIn.valid) begin
         retired <= retired + 1'b1;
         if (rtIn.halt || rtIn.illegal) begin
            halt <= 1'b1;
         end
         if (rtIn.illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module procTb -f all.f -o procSim &&
out=$(./obj_dir/procSim) &&
echo "$out" &&
echo "$out" | grep -q "Everything OK" &&
echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

//--- tb/clockGen.sv
// Testbench clock source
`timescale 1ns/1ps

module clockGen (
   output logic clk
);

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

endmodule

//--- tb/procTb.sv
// Processor core testbench
`timescale 1ns/1ps

module procTb;

   localparam int NumPrograms  = 10;
   localparam int NumRuns      = NumPrograms + 3;
   localparam int AccessCycles = 3;
   localparam int CycleLimit   = NumRuns * (AccessCycles * (256 + 8) + 300) + 200;

   logic               clk;
   logic               reset;
   logic               psel;
   logic               penable;
   logic               pwrite;
   procPkg::apbAddr_t  paddr;
   procPkg::word_t     pwdata;
   logic               pready;
   procPkg::word_t     prdata;
   logic               pslverr;
   logic               halt;
   logic               err;

   logic [15:0]        lfsr;
   procPkg::word_t     prog [64];
   int                 progLen;
   procPkg::word_t     modelRegs [8];
   logic               modelErr;
   int                 checkCount = 0;
   int                 errorCount = 0;
   int                 cycles = 0;

   clockGen clkSource (.clk(clk));

   proc i_dut (
      .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .pready, .prdata, .pslverr, .halt, .err
   );

   // Taps at 16, 14, 13 and 11 with one step per bit
   function automatic logic [15:0] randBits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   // Half the time reuse the last destination
   function automatic procPkg::regIdx_t pickReg(input procPkg::regIdx_t last);
      if (randBits(1) == 16'd1) begin
         return last;
      end
      return 3'(randBits(3));
   endfunction

   task automatic check(input string name, input procPkg::word_t expected,
                        input procPkg::word_t actual);
      checkCount++;
      if (expected !== actual) begin
         errorCount++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic apbAccess(input logic write, input procPkg::apbAddr_t addr,
                            input procPkg::word_t wdata, output procPkg::word_t rdata,
                            output logic slverr);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      rdata  = prdata;
      slverr = pslverr;
      check("pready", 16'd1, {15'd0, pready});
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic busWrite(input procPkg::apbAddr_t addr, input procPkg::word_t data,
                           input logic expErr, input string name);
      procPkg::word_t unused;
      logic           slverr;
      apbAccess(1'b1, addr, data, unused, slverr);
      check(name, {15'd0, expErr}, {15'd0, slverr});
   endtask

   task automatic busRead(input procPkg::apbAddr_t addr, output procPkg::word_t data,
                          input logic expErr, input string name);
      logic slverr;
      apbAccess(1'b0, addr, 16'd0, data, slverr);
      check(name, {15'd0, expErr}, {15'd0, slverr});
   endtask

   // Sequential ISA model that returns the retired count
   function automatic int runModel();
      procPkg::word_t w;
      procPkg::word_t a;
      procPkg::word_t b;
      procPkg::word_t r;
      logic [3:0]     op;
      int             count;
      count    = 0;
      modelErr = 1'b0;
      for (int i = 0; i < progLen; i++) begin
         w  = prog[i];
         op = w[15:12];
         a  = modelRegs[w[8:6]];
         b  = modelRegs[w[5:3]];
         count++;
         if (op == procPkg::OpHalt) begin
            return count;
         end
         if (op > procPkg::OpSlbi) begin
            modelErr = 1'b1;
            return count;
         end
         case (op)
            procPkg::OpAdd:  r = a + b;
            procPkg::OpSub:  r = a - b;
            procPkg::OpAnd:  r = a & b;
            procPkg::OpXor:  r = a ^ b;
            procPkg::OpSll:  r = a << b[3:0];
            procPkg::OpRor: begin
               r = a;
               repeat (b[3:0]) begin
                  r = {r[0], r[15:1]};
               end
            end
            procPkg::OpSeq:  r = (a == b) ? 16'd1 : 16'd0;
            procPkg::OpSlt:  r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            procPkg::OpLbi:  r = {{8{w[7]}}, w[7:0]};
            procPkg::OpSlbi: r = {modelRegs[w[11:9]][7:0], w[7:0]};
            default:         r = 16'd0;
         endcase
         if (op != procPkg::OpNop) begin
            modelRegs[w[11:9]] = r;
         end
      end
      return count;
   endfunction

   task automatic makeProgram(input logic withIllegal);
      int               len;
      int               bad;
      logic [3:0]       op;
      procPkg::regIdx_t rd;
      procPkg::regIdx_t lastRd;
      lastRd = 3'(randBits(3));
      len    = 20 + int'(randBits(6) % 16'd41);
      for (int i = 0; i < len; i++) begin
         op      = 4'(randBits(4) % 16'd11);
         rd      = 3'(randBits(3));
         prog[i] = {op, rd, pickReg(lastRd), pickReg(lastRd), 3'(randBits(3))};
         lastRd  = rd;
      end
      prog[len] = {procPkg::OpHalt, 12'h000};
      progLen   = len + 1;
      if (withIllegal) begin
         bad       = 5 + int'(randBits(4));
         op        = 4'(11 + int'(randBits(2)));
         prog[bad] = {op, prog[bad][11:0]};
      end
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         busWrite(12'(i * 4), prog[i], 1'b0, "load pslverr");
      end
   endtask

   task automatic startRun();
      busWrite(procPkg::AddrCtrl, 16'd1, 1'b0, "start pslverr");
   endtask

   task automatic waitHalt();
      procPkg::word_t status;
      status = '0;
      while (status[1] == 1'b0) begin
         busRead(procPkg::AddrCtrl, status, 1'b0, "poll pslverr");
      end
   endtask

   task automatic checkState(input string name);
      procPkg::word_t value;
      int             expCount;
      expCount = runModel();
      for (int r = 0; r < 8; r++) begin
         busRead(12'(int'(procPkg::AddrRegBase) + 4 * r), value, 1'b0, "reg pslverr");
         check($sformatf("%s r%0d", name, r), modelRegs[r], value);
      end
      busRead(procPkg::AddrRetired, value, 1'b0, "retired pslverr");
      check({name, " retired"}, 16'(expCount), value);
      busRead(procPkg::AddrCtrl, value, 1'b0, "status pslverr");
      check({name, " status"}, {13'd0, modelErr, 1'b1, 1'b0}, value);
      check({name, " halt port"}, 16'd1, {15'd0, halt});
      check({name, " err port"}, {15'd0, modelErr}, {15'd0, err});
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CycleLimit) begin
         $display("Timeout: run did not finish within %0d cycles", CycleLimit);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      procPkg::word_t value;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      lfsr    = 16'd38770;
      for (int r = 0; r < 8; r++) begin
         modelRegs[r] = '0;
      end
      repeat (8) @(negedge clk);
      reset = 1'b0;

      busRead(procPkg::AddrCtrl, value, 1'b0, "reset status pslverr");
      check("reset status", 16'd0, value);
      for (int r = 0; r < 8; r++) begin
         busRead(12'(int'(procPkg::AddrRegBase) + 4 * r), value, 1'b0, "reg pslverr");
         check($sformatf("reset r%0d", r), 16'd0, value);
      end

      for (int p = 0; p < NumPrograms; p++) begin
         makeProgram(1'b0);
         loadProgram();
         startRun();
         waitHalt();
         checkState($sformatf("program %0d", p));
      end

      makeProgram(1'b1);
      loadProgram();
      startRun();
      waitHalt();
      checkState("illegal opcode");

      // Overwrite with HALT must be rejected while running
      makeProgram(1'b0);
      loadProgram();
      startRun();
      busWrite(12'h000, {procPkg::OpHalt, 12'h000}, 1'b1, "imem write while running");
      waitHalt();
      checkState("busy write");
      startRun();
      waitHalt();
      checkState("rerun");

      busRead(12'h408, value, 1'b1, "unmapped read");
      busWrite(12'h460, 16'h1234, 1'b1, "unmapped write");
      busRead(12'h002, value, 1'b1, "unaligned read");

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
